/* test/dump_golden.txt */
# cmd stall npc pc ir ctl a b imm y mdr expected_line
# expected_line is the printed text without cr lf, a lone - means no output
50 0 00000104 00000100 8c220008 3 0000000a fffffff0 00000008 00000012 deadbeef NPC=00000104PC=00000100IR=8C220008CTL=00000003A=0000000AB=FFFFFFF0IMM=00000008Y=00000012MDR=DEADBEEF
50 1 1000002c 10000028 afbf001c a 7fffffff 00000001 0000001c 80000000 cafef00d NPC=1000002CPC=10000028IR=AFBF001CCTL=0000000AA=7FFFFFFFB=00000001IMM=0000001CY=80000000MDR=CAFEF00D
51 0 11111111 22222222 33333333 4 55555555 66666666 77777777 88888888 99999999 -
50 1 ffffffff fffffffc 00000000 f 12345678 9abcdef0 ffffff80 0f0f0f0f 00c0ffee NPC=FFFFFFFFPC=FFFFFFFCIR=00000000CTL=0000000FA=12345678B=9ABCDEF0IMM=FFFFFF80Y=0F0F0F0FMDR=00C0FFEE
00 0 aaaaaaaa bbbbbbbb cccccccc c dddddddd eeeeeeee ffffffff 01234567 89abcdef -
50 0 00400004 00400000 3c011001 0 00000000 10010000 00001001 10011001 0000beef NPC=00400004PC=00400000IR=3C011001CTL=00000000A=00000000B=10010000IMM=00001001Y=10011001MDR=0000BEEF

/* all.f */
logic/dbg_pkg.sv
logic/dump_sequencer.sv
logic/item_fifo.sv
logic/hex_serializer.sv
logic/datapath_printer.sv
test/tb_clock_gen.sv
test/datapath_printer_props.sv
test/datapath_printer_tb.sv

/* Makefile */
TB  := datapath_printer_tb
SIM := obj_dir/V$(TB)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): all.f $(wildcard logic/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module $(TB) -o V$(TB)

run: build
	./$(SIM) | tee sim.log
	grep -q "^RESULT: PASS" sim.log

lint:
	verilator --lint-only --timing -Wall -f all.f --top-module $(TB)
	verilator --lint-only -Wall logic/dbg_pkg.sv logic/dump_sequencer.sv logic/item_fifo.sv \
		logic/hex_serializer.sv logic/datapath_printer.sv --top-module datapath_printer

clean:
	rm -rf obj_dir sim.log

/* test/datapath_printer_tb.sv */
`timescale 1ns/100ps

module datapath_printer_tb;

    localparam int BYTE_TIMEOUT = 200; // cycles allowed per byte
    localparam int DONE_TIMEOUT = 20;
    localparam int QUIET_CYCLES = 60;  // window that must stay silent

    logic        clk;
    logic        rstn;
    logic [7:0]  cmd;
    logic [31:0] npc;
    logic [31:0] pc;
    logic [31:0] ir;
    logic [3:0]  ctl;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] y;
    logic [31:0] mdr;
    logic [7:0]  tx_data;
    logic        tx_valid;
    logic        tx_ready = 1'b1;
    logic        done;

    logic        stall_mode = 1'b0;
    int          seed;
    int          errors;
    int          timeouts;
    int          done_count = 0;

    tb_clock_gen u_clk (.clk(clk), .rstn(rstn));

    datapath_printer u_dut (
        .clk(clk), .rstn(rstn), .cmd(cmd),
        .npc(npc), .pc(pc), .ir(ir), .ctl(ctl),
        .a(a), .b(b), .imm(imm), .y(y), .mdr(mdr),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready), .done(done)
    );

    // sink readiness is decided on the edge and applied 1 ns later
    always @(posedge clk) begin
        logic [31:0] rnd;
        logic        next_ready;
        rnd        = $random(seed);
        next_ready = stall_mode ? rnd[0] : 1'b1;
        #1 tx_ready = next_ready;
    end

    always @(negedge clk) begin
        if (done) begin
            done_count++;
        end
    end

    function automatic int token_len(input logic [8*128-1:0] t);
        int n;
        n = 0;
        for (int k = 0; k < 128; k++) begin
            if (t[8*k +: 8] != 8'h00) begin
                n = k + 1;
            end
        end
        return n;
    endfunction

    task automatic take_byte(output logic [7:0] got, output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < BYTE_TIMEOUT) begin
            @(negedge clk);
            if (tx_valid && tx_ready) begin
                got  = tx_data; // transfers on the coming rising edge
                seen = 1'b1;
            end
            waited++;
        end
    endtask

    task automatic wait_done(output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            seen = done;
            waited++;
        end
    endtask

    task automatic expect_silence(input int case_no);
        for (int k = 0; k < QUIET_CYCLES; k++) begin
            @(negedge clk);
            if (tx_valid) begin
                $display("case %0d: unexpected byte 0x%02h offered at %0t",
                         case_no, tx_data, $time);
                errors++;
            end
        end
    endtask

    initial begin
        int               fd;
        int               n;
        int               case_no;
        int               len;
        int               done_before;
        int               waited;
        bit               seen;
        bit               abort;
        logic [7:0]       got;
        logic [7:0]       want;
        logic [8*256-1:0] line;
        logic [8*128-1:0] tok;
        logic [7:0]       c_cmd;
        logic [3:0]       c_stall;
        logic [31:0]      v [9];
        seed     = 95071;
        errors   = 0;
        timeouts = 0;
        case_no  = 0;
        abort    = 1'b0;
        cmd      = 8'h00;
        npc      = '0;
        pc       = '0;
        ir       = '0;
        ctl      = '0;
        a        = '0;
        b        = '0;
        imm      = '0;
        y        = '0;
        mdr      = '0;
        fd = $fopen("test/dump_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/dump_golden.txt");
            errors++;
            abort = 1'b1;
        end
        waited = 0;
        while (rstn !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (rstn !== 1'b1) begin
            $display("timeout waiting for reset release");
            timeouts++;
            abort = 1'b1;
        end
        @(posedge clk);
        #1;
        while (!abort && !$feof(fd)) begin
            line = '0;
            tok  = '0;
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %s",
                        c_cmd, c_stall, v[0], v[1], v[2], v[3], v[4],
                        v[5], v[6], v[7], v[8], tok);
            if (n == 12) begin // comment and blank lines fall through
                case_no++;
                done_before = done_count;
                stall_mode  = c_stall[0];
                cmd = c_cmd;
                npc = v[0];
                pc  = v[1];
                ir  = v[2];
                ctl = v[3][3:0];
                a   = v[4];
                b   = v[5];
                imm = v[6];
                y   = v[7];
                mdr = v[8];
                @(posedge clk); // trigger edge when the command dumps
                #1;
                npc = $random(seed); // later values must not reach the line
                pc  = $random(seed);
                ir  = $random(seed);
                ctl = 4'($random(seed));
                a   = $random(seed);
                b   = $random(seed);
                imm = $random(seed);
                y   = $random(seed);
                mdr = $random(seed);
                len = (tok == "-") ? 0 : token_len(tok);
                for (int i = 0; len > 0 && i < len + 2 && !abort; i++) begin
                    if (i < len) begin
                        want = tok[8*(len-1-i) +: 8];
                    end else begin
                        want = (i == len) ? 8'h0D : 8'h0A;
                    end
                    take_byte(got, seen);
                    if (!seen) begin
                        $display("timeout waiting for byte %0d of case %0d", i, case_no);
                        timeouts++;
                        abort = 1'b1;
                    end else if (got !== want) begin
                        $display("FAILED t=%0t tx_data expected 0x%02h actual 0x%02h",
                                 $time, want, got);
                        errors++;
                    end
                end
                if (!abort && len > 0) begin
                    wait_done(seen);
                    if (!seen) begin
                        $display("timeout waiting for done in case %0d", case_no);
                        timeouts++;
                        abort = 1'b1;
                    end
                end
                if (!abort) begin
                    expect_silence(case_no); // cmd still held here
                    if (done_count - done_before != ((len > 0) ? 1 : 0)) begin
                        $display("FAILED t=%0t done pulses expected %0d actual %0d",
                                 $time, (len > 0) ? 1 : 0, done_count - done_before);
                        errors++;
                    end
                end
                @(posedge clk);
                #1;
                cmd = 8'h00; // release so the next dump can arm
                @(posedge clk);
                #1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (case_no == 0 && !abort) begin
            $display("no cases found in test/dump_golden.txt");
            errors++;
        end
        $display("cases=%0d errors=%0d timeouts=%0d", case_no, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* test/datapath_printer_props.sv */
`timescale 1ns/100ps

module datapath_printer_props import dbg_pkg::*; (
    input logic                  clk,
    input logic                  rstn,
    input logic                  push,
    input logic [CREDIT_W-1:0]   credits,
    input logic [FIFO_PTR_W:0]   fifo_count,
    input logic [7:0]            tx_data,
    input logic                  tx_valid,
    input logic                  tx_ready,
    input logic                  done
);

    credit_cap: assert property (@(posedge clk) disable iff (!rstn)
        credits <= CREDIT_W'(FIFO_DEPTH))
        else $error("credit count %0d above fifo depth", credits);

    // a push with no credit left would land in a full fifo
    push_needs_credit: assert property (@(posedge clk) disable iff (!rstn)
        push |-> (fifo_count < (FIFO_PTR_W+1)'(FIFO_DEPTH)))
        else $error("push issued into a full fifo");

    // byte port holds its data while the sink stalls
    tx_hold: assert property (@(posedge clk) disable iff (!rstn)
        (tx_valid && !tx_ready) |=> $stable(tx_data))
        else $error("tx_data changed under stall");

    done_single: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done)
        else $error("done held for more than one cycle");

endmodule

bind datapath_printer datapath_printer_props u_props (
    .clk(clk), .rstn(rstn), .push(push), .credits(u_seq.credits),
    .fifo_count(u_fifo.count),
    .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready), .done(done)
);

/* test/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rstn
);

    localparam int RST_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rstn = 1'b1; // released just after an edge, like all other inputs
    end

endmodule

/* logic/datapath_printer.sv */
`timescale 1ns/100ps

module datapath_printer import dbg_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic [7:0]  cmd,
    input  logic [31:0] npc,
    input  logic [31:0] pc,
    input  logic [31:0] ir,
    input  logic [3:0]  ctl,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  logic [31:0] imm,
    input  logic [31:0] y,
    input  logic [31:0] mdr,
    output logic [7:0]  tx_data,
    output logic        tx_valid,
    input  logic        tx_ready,
    output logic        done
);

    logic                   push;
    logic [ITEM_KIND_W-1:0] push_kind;
    logic [ITEM_DATA_W-1:0] push_data;
    logic                   credit_return;
    logic                   not_empty;
    logic [ITEM_KIND_W-1:0] head_kind;
    logic [ITEM_DATA_W-1:0] head_data;
    logic                   pop;

    dump_sequencer u_seq (
        .clk(clk), .rstn(rstn), .cmd(cmd),
        .npc(npc), .pc(pc), .ir(ir), .ctl(ctl),
        .a(a), .b(b), .imm(imm), .y(y), .mdr(mdr),
        .push(push), .push_kind(push_kind), .push_data(push_data),
        .credit_return(credit_return)
    );

    item_fifo u_fifo (
        .clk(clk), .rstn(rstn),
        .push(push), .push_kind(push_kind), .push_data(push_data),
        .pop(pop), .not_empty(not_empty),
        .head_kind(head_kind), .head_data(head_data),
        .credit_return(credit_return)
    );

    hex_serializer u_ser (
        .clk(clk), .rstn(rstn),
        .not_empty(not_empty), .head_kind(head_kind), .head_data(head_data),
        .pop(pop),
        .tx_data(tx_data), .tx_valid(tx_valid), .tx_ready(tx_ready),
        .done(done)
    );

endmodule

/* logic/hex_serializer.sv */
`timescale 1ns/100ps

module hex_serializer import dbg_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   not_empty,
    input  logic [ITEM_KIND_W-1:0] head_kind,
    input  logic [ITEM_DATA_W-1:0] head_data,
    output logic                   pop,
    output logic [7:0]             tx_data,
    output logic                   tx_valid,
    input  logic                   tx_ready,
    output logic                   done
);

    logic                   busy;     // an item is held and being sent
    logic [ITEM_KIND_W-1:0] kind_q;
    logic [ITEM_DATA_W-1:0] shift_q;  // word digits leave from the top nibble
    logic [3:0]             left_q;   // bytes still to send after the current one
    logic                   xfer;

    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        logic [7:0] code;
        if (nib < 4'd10) begin
            code = 8'h30 + {4'h0, nib}; // '0'..'9'
        end else begin
            code = 8'h37 + {4'h0, nib}; // 'A'..'F'
        end
        return code;
    endfunction

    assign pop      = !busy && not_empty;
    assign tx_valid = busy;
    assign xfer     = busy && tx_ready;

    // byte on the port is a pure function of held registers, so it stays stable under stall
    always_comb begin
        tx_data = shift_q[7:0];
        case (kind_q)
            KIND_WORD: tx_data = hex_ascii(shift_q[31:28]);
            KIND_END:  tx_data = (left_q != 4'd0) ? 8'h0D : 8'h0A; // cr then lf
            default:   tx_data = shift_q[7:0];
        endcase
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q <= head_data;
        end else if (xfer && kind_q == KIND_WORD) begin
            shift_q <= {shift_q[ITEM_DATA_W-5:0], 4'h0}; // next nibble to the top
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy   <= 1'b0;
            kind_q <= KIND_CHAR;
            left_q <= '0;
            done   <= 1'b0;
        end else begin
            done <= 1'b0;
            if (pop) begin
                busy   <= 1'b1;
                kind_q <= head_kind;
                case (head_kind)
                    KIND_WORD: left_q <= 4'd7; // eight hex digits
                    KIND_END:  left_q <= 4'd1; // cr, lf
                    default:   left_q <= 4'd0;
                endcase
            end else if (xfer) begin
                if (left_q == 4'd0) begin
                    busy <= 1'b0;
                    if (kind_q == KIND_END) begin
                        done <= 1'b1; // line finished
                    end
                end else begin
                    left_q <= left_q - 4'd1;
                end
            end
        end
    end

endmodule

/* logic/item_fifo.sv */
`timescale 1ns/100ps

module item_fifo import dbg_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   push,
    input  logic [ITEM_KIND_W-1:0] push_kind,
    input  logic [ITEM_DATA_W-1:0] push_data,
    input  logic                   pop,
    output logic                   not_empty,
    output logic [ITEM_KIND_W-1:0] head_kind,
    output logic [ITEM_DATA_W-1:0] head_data,
    output logic                   credit_return
);

    logic [ITEM_KIND_W-1:0] kind_mem [FIFO_DEPTH];
    logic [ITEM_DATA_W-1:0] data_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0]  wr_ptr;
    logic [FIFO_PTR_W-1:0]  rd_ptr;
    logic [FIFO_PTR_W:0]    count; // one bit wider, holds FIFO_DEPTH

    // no overflow check, the producer credits cap occupancy at FIFO_DEPTH
    always_ff @(posedge clk) begin
        if (push) begin
            kind_mem[wr_ptr] <= push_kind;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps at depth 4
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            unique case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    assign not_empty = (count != '0);
    assign head_kind = kind_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];

    // every freed slot goes straight back to the producer
    assign credit_return = pop;

endmodule

/* logic/dump_sequencer.sv */
`timescale 1ns/100ps

module dump_sequencer import dbg_pkg::*; (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [7:0]             cmd,
    input  logic [31:0]            npc,
    input  logic [31:0]            pc,
    input  logic [31:0]            ir,
    input  logic [3:0]             ctl,
    input  logic [31:0]            a,
    input  logic [31:0]            b,
    input  logic [31:0]            imm,
    input  logic [31:0]            y,
    input  logic [31:0]            mdr,
    output logic                   push,
    output logic [ITEM_KIND_W-1:0] push_kind,
    output logic [ITEM_DATA_W-1:0] push_data,
    input  logic                   credit_return
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_LABEL,
        S_WORD,
        S_END
    } seq_state_t;

    seq_state_t          state;
    logic [3:0]          field_idx;  // 0..NUM_FIELDS-1
    logic [1:0]          char_idx;   // position inside the label
    logic [CREDIT_W-1:0] credits;
    logic                armed;
    logic                trigger;
    logic                last_char;
    logic [31:0]         snap [NUM_FIELDS];

    assign trigger   = (state == S_IDLE) && armed && (cmd == DUMP_CMD);
    assign last_char = ({1'b0, char_idx} == (label_len[field_idx] - 3'd1));

    // snapshot taken on the trigger edge, later input changes are ignored
    always_ff @(posedge clk) begin
        if (trigger) begin
            snap[0] <= npc;
            snap[1] <= pc;
            snap[2] <= ir;
            snap[3] <= {28'h0, ctl}; // zero-extended control state
            snap[4] <= a;
            snap[5] <= b;
            snap[6] <= imm;
            snap[7] <= y;
            snap[8] <= mdr;
        end
    end

    // current item, offered only while a credit is held
    always_comb begin
        push      = (state != S_IDLE) && (credits != '0);
        push_kind = KIND_CHAR;
        push_data = '0;
        case (state)
            S_LABEL: push_data = ITEM_DATA_W'(label_chars[field_idx][char_idx]);
            S_WORD: begin
                push_kind = KIND_WORD;
                push_data = snap[field_idx];
            end
            S_END:   push_kind = KIND_END;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= S_IDLE;
            field_idx <= '0;
            char_idx  <= '0;
            armed     <= 1'b1;
        end else begin
            unique case (state)
                S_IDLE: begin
                    if (trigger) begin
                        state     <= S_LABEL;
                        field_idx <= '0;
                        char_idx  <= '0;
                    end else if (cmd != DUMP_CMD) begin
                        armed <= 1'b1; // command released, next one may dump
                    end
                end
                S_LABEL: begin
                    if (push) begin
                        if (last_char) begin
                            state    <= S_WORD;
                            char_idx <= '0;
                        end else begin
                            char_idx <= char_idx + 2'd1;
                        end
                    end
                end
                S_WORD: begin
                    if (push) begin
                        if (field_idx == 4'(NUM_FIELDS - 1)) begin
                            state <= S_END;
                        end else begin
                            field_idx <= field_idx + 4'd1;
                            state     <= S_LABEL;
                        end
                    end
                end
                S_END: begin
                    if (push) begin
                        state <= S_IDLE;
                        armed <= 1'b0; // wait for cmd to drop before re-arming
                    end
                end
            endcase
        end
    end

    // one credit out per push, one back per fifo pop
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits <= CREDIT_W'(FIFO_DEPTH);
        end else begin
            unique case ({push, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* logic/dbg_pkg.sv */
package dbg_pkg;

    // item kind field, first in every FIFO entry
    localparam int ITEM_KIND_W = 2;

    localparam logic [ITEM_KIND_W-1:0] KIND_CHAR = 2'd0; // one ascii byte in data[7:0]
    localparam logic [ITEM_KIND_W-1:0] KIND_WORD = 2'd1; // 32-bit value, printed as hex
    localparam logic [ITEM_KIND_W-1:0] KIND_END  = 2'd2; // cr lf plus done pulse

    localparam int ITEM_DATA_W = 32;

    // item buffer sizing, depth doubles as the starting credit count
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;
    localparam int CREDIT_W   = 3;

    localparam logic [7:0] DUMP_CMD = 8'h50; // debug command that asks for a dump

    localparam int NUM_FIELDS = 9;

    // Label text per field, first byte at index 0. Unused slots are zero
    // and never sent, label_len decides how many bytes go out.
    localparam logic [7:0] label_chars [NUM_FIELDS][4] = '{
        '{8'h4E, 8'h50, 8'h43, 8'h3D}, // NPC=
        '{8'h50, 8'h43, 8'h3D, 8'h00}, // PC=
        '{8'h49, 8'h52, 8'h3D, 8'h00}, // IR=
        '{8'h43, 8'h54, 8'h4C, 8'h3D}, // CTL=
        '{8'h41, 8'h3D, 8'h00, 8'h00}, // A=
        '{8'h42, 8'h3D, 8'h00, 8'h00}, // B=
        '{8'h49, 8'h4D, 8'h4D, 8'h3D}, // IMM=
        '{8'h59, 8'h3D, 8'h00, 8'h00}, // Y=
        '{8'h4D, 8'h44, 8'h52, 8'h3D}  // MDR=
    };

    localparam logic [2:0] label_len [NUM_FIELDS] = '{
        3'd4, // npc
        3'd3, // pc
        3'd3, // ir
        3'd4, // ctl
        3'd2, // a
        3'd2, // b
        3'd4, // imm
        3'd2, // y
        3'd4  // mdr
    };

endpackage
